/* verilog/alu_params.svh */
////////////////////////////////////////////////////////////
// width macros for the integer execution unit
// ALU_SHAMT_BITS must equal log2 of ALU_XLEN
////////////////////////////////////////////////////////////

`ifndef ALU_PARAMS_SVH
`define ALU_PARAMS_SVH

// operand and result width
`define ALU_XLEN 64

// low bits of operand b taken as the shift amount
`define ALU_SHAMT_BITS 6

`endif

/* verilog/alu_pkg.sv */
////////////////////////////////////////////////////////////
// shared types of the integer execution unit
// function codes follow the RV64I funct3 selector
// sub is only looked at for OP_ADD, arith only for OP_SRL
////////////////////////////////////////////////////////////

`include "alu_params.svh"

package alu_pkg;

    // three-bit function select
    typedef enum logic [2:0] {
        OP_ADD  = 3'd0,
        OP_SLL  = 3'd1,
        OP_SLT  = 3'd2,
        OP_SLTU = 3'd3,
        OP_XOR  = 3'd4,
        OP_SRL  = 3'd5,
        OP_OR   = 3'd6,
        OP_AND  = 3'd7
    } alu_op_e;

    // one operation as handed over by the requester
    typedef struct packed {
        logic [`ALU_XLEN-1:0] a;
        logic [`ALU_XLEN-1:0] b;
        alu_op_e              op;
        logic                 sub;
        logic                 arith;
    } alu_req_t;

    // adder status
    typedef struct packed {
        logic zero;
        logic negative;
        logic carry;
        logic overflow;
    } alu_flags_t;

    typedef struct packed {
        logic [`ALU_XLEN-1:0] result;
        alu_flags_t           flags;
    } alu_rsp_t;

endpackage

/* verilog/alu_handshake.sv */
////////////////////////////////////////////////////////////
// four-phase req/ack control with operand and response regs
// req_data must be stable while req is high
// one operation in flight, at least four edges per request
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module alu_handshake
    import alu_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     req,
    input  alu_req_t req_data,
    output logic     ack,
    output alu_req_t opnd,
    input  alu_rsp_t merged,
    output alu_rsp_t rsp
);

    typedef enum logic [1:0] {
        ST_IDLE    = 2'd0,
        ST_COMPUTE = 2'd1,
        ST_HOLD    = 2'd2
    } hs_state_e;

    hs_state_e state;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_IDLE;
            opnd  <= '0;
            rsp   <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    // capture operands at edge E
                    if (req) begin
                        opnd  <= req_data;
                        state <= ST_COMPUTE;
                    end
                end
                ST_COMPUTE: begin
                    // datapath settled, register the answer
                    rsp   <= merged;
                    state <= ST_HOLD;
                end
                ST_HOLD: begin
                    // return to zero once req drops
                    if (!req) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // ack comes straight from the state register
    assign ack = (state == ST_HOLD);

    // ack only answers a live request
    a_ack_rise_with_req: assert property (@(posedge clk) disable iff (rst)
        $rose(ack) |-> $past(req));

    // response frozen for the whole ack phase
    a_rsp_stable: assert property (@(posedge clk) disable iff (rst)
        (ack && $past(ack)) |-> $stable(rsp));

    a_ack_fall_after_req: assert property (@(posedge clk) disable iff (rst)
        $fell(ack) |-> !$past(req));

endmodule

/* verilog/alu_arith.sv */
////////////////////////////////////////////////////////////
// adder/subtractor with zero, negative, carry, overflow
// compare codes always subtract so the flags order a and b
// carry is the raw carry out, set means no borrow
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

`include "alu_params.svh"

module alu_arith
    import alu_pkg::*;
(
    input  alu_req_t             opnd,
    output logic [`ALU_XLEN-1:0] sum,
    output alu_flags_t           add_flags
);

    logic                 sub_en;
    logic [`ALU_XLEN-1:0] b_eff;
    logic                 carry_out;

    // subtract for sub, slt and sltu
    always_comb begin
        case (opnd.op)
            OP_ADD:          sub_en = opnd.sub;
            OP_SLT, OP_SLTU: sub_en = 1'b1;
            default:         sub_en = 1'b0;
        endcase
    end

    // a + ~b + 1 when subtracting
    assign b_eff = sub_en ? ~opnd.b : opnd.b;

    assign {carry_out, sum} = {1'b0, opnd.a} + {1'b0, b_eff}
                            + {{`ALU_XLEN{1'b0}}, sub_en};

    assign add_flags.zero     = ~(|sum);
    assign add_flags.negative = sum[`ALU_XLEN-1];
    assign add_flags.carry    = carry_out;
    // same-sign inputs, sum sign flipped
    assign add_flags.overflow = ~(opnd.a[`ALU_XLEN-1] ^ b_eff[`ALU_XLEN-1])
                              & (opnd.a[`ALU_XLEN-1] ^ sum[`ALU_XLEN-1]);

    always_comb begin
        if (!$isunknown({opnd.a, opnd.b, opnd.op, opnd.sub})) begin
            a_flags_known: assert final (!$isunknown({add_flags.carry, add_flags.overflow}))
                else $error("alu_arith: carry or overflow unknown for known operands");
        end
    end

endmodule

/* verilog/alu_logic_shift.sv */
////////////////////////////////////////////////////////////
// barrel shifts and bitwise functions
// shift amount is the low ALU_SHAMT_BITS of b
// output is zero for the adder and compare codes
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

`include "alu_params.svh"

module alu_logic_shift
    import alu_pkg::*;
(
    input  alu_req_t             opnd,
    output logic [`ALU_XLEN-1:0] logic_result
);

    logic [`ALU_SHAMT_BITS-1:0] shamt;
    logic [`ALU_XLEN-1:0]       shift_right;

    assign shamt = opnd.b[`ALU_SHAMT_BITS-1:0];

    // sign fill only when arith is set
    always_comb begin
        if (opnd.arith) begin
            shift_right = $signed(opnd.a) >>> shamt;
        end else begin
            shift_right = opnd.a >> shamt;
        end
    end

    always_comb begin
        case (opnd.op)
            OP_SLL: begin
                logic_result = opnd.a << shamt;
            end
            OP_SRL: begin
                logic_result = shift_right;
            end
            OP_XOR: begin
                logic_result = opnd.a ^ opnd.b;
            end
            OP_OR: begin
                logic_result = opnd.a | opnd.b;
            end
            OP_AND: begin
                logic_result = opnd.a & opnd.b;
            end
            // add, slt, sltu come from the adder
            default: begin
                logic_result = '0;
            end
        endcase
    end

endmodule

/* verilog/alu_result_merge.sv */
////////////////////////////////////////////////////////////
// picks the result by function code and masks the flags
// compare results are 0 or 1, taken from the adder flags
// flags read zero for the logic and shift codes
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

`include "alu_params.svh"

module alu_result_merge
    import alu_pkg::*;
(
    input  alu_op_e              op,
    input  logic [`ALU_XLEN-1:0] sum,
    input  alu_flags_t           add_flags,
    input  logic [`ALU_XLEN-1:0] logic_result,
    output alu_rsp_t             merged
);

    logic lt_signed;
    logic lt_unsigned;

    // a < b signed when sign and overflow disagree
    assign lt_signed   = add_flags.negative ^ add_flags.overflow;
    // borrow out means a < b unsigned
    assign lt_unsigned = ~add_flags.carry;

    always_comb begin
        case (op)
            OP_ADD: begin
                merged.result = sum;
                merged.flags  = add_flags;
            end
            OP_SLT: begin
                merged.result = {{(`ALU_XLEN-1){1'b0}}, lt_signed};
                merged.flags  = add_flags;
            end
            OP_SLTU: begin
                merged.result = {{(`ALU_XLEN-1){1'b0}}, lt_unsigned};
                merged.flags  = add_flags;
            end
            default: begin
                merged.result = logic_result;
                merged.flags  = '0;
            end
        endcase
    end

    always_comb begin
        if (op == OP_SLT || op == OP_SLTU) begin
            a_cmp_upper_zero: assert final (merged.result[`ALU_XLEN-1:1] == '0)
                else $error("alu_result_merge: compare result wider than one bit");
        end
    end

endmodule

/* verilog/alu_unit.sv */
////////////////////////////////////////////////////////////
// RV64I integer execution unit behind a four-phase handshake
// rsp is valid while ack is high
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

`include "alu_params.svh"

module alu_unit
    import alu_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     req,
    input  alu_req_t req_data,
    output logic     ack,
    output alu_rsp_t rsp
);

    alu_req_t             opnd;
    logic [`ALU_XLEN-1:0] sum;
    alu_flags_t           add_flags;
    logic [`ALU_XLEN-1:0] logic_result;
    alu_rsp_t             merged;

    alu_handshake u_handshake (
        .clk      (clk),
        .rst      (rst),
        .req      (req),
        .req_data (req_data),
        .ack      (ack),
        .opnd     (opnd),
        .merged   (merged),
        .rsp      (rsp)
    );

    alu_arith u_arith (
        .opnd      (opnd),
        .sum       (sum),
        .add_flags (add_flags)
    );

    alu_logic_shift u_logic_shift (
        .opnd         (opnd),
        .logic_result (logic_result)
    );

    alu_result_merge u_result_merge (
        .op           (opnd.op),
        .sum          (sum),
        .add_flags    (add_flags),
        .logic_result (logic_result),
        .merged       (merged)
    );

endmodule

/* bench/tb_alu_unit.sv */
////////////////////////////////////////////////////////////
// testbench for the integer execution unit
// expected responses come from a model of the RV64I rules
// random operands use a fixed seed, one request at a time
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

`include "alu_params.svh"

module tb_alu_unit
    import alu_pkg::*;
();

    localparam int MSB        = `ALU_XLEN - 1;
    localparam int CLK_PERIOD = 100;
    // requests summed over all tests below
    localparam int TXN_TOTAL  = 319;

    logic     clk;
    logic     rst;
    logic     req;
    alu_req_t req_data;
    logic     ack;
    alu_rsp_t rsp;

    alu_rsp_t       exp_rsp;
    string          test_name;
    int             err_count;
    int             test_start_errs;
    int             tests_pass;
    int             tests_fail;
    int             sent_count;
    int             sent_start;
    int             ack_rises;
    int             rises_start;
    logic           ack_seen;
    logic [MSB:0]   corner [4];

    alu_unit u_dut (
        .clk      (clk),
        .rst      (rst),
        .req      (req),
        .req_data (req_data),
        .ack      (ack),
        .rsp      (rsp)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // one count per rising ack, away from the clock edge
    always @(negedge clk) begin
        if (rst) begin
            ack_seen <= 1'b0;
        end else begin
            if (ack && !ack_seen) begin
                ack_rises <= ack_rises + 1;
            end
            ack_seen <= ack;
        end
    end

    check_rsp: assert property (@(posedge clk) disable iff (rst) $rose(ack) |-> rsp == exp_rsp)
        else begin
            $display("Fail %s expected %h actual %h", test_name, exp_rsp, rsp);
            err_count++;
        end

    ack_needs_req: assert property (@(posedge clk) disable iff (rst) $rose(ack) |-> req)
        else begin
            $display("%s: ack rose while req was low", test_name);
            err_count++;
        end

    ack_arrives: assert property (@(posedge clk) disable iff (rst) $rose(req) |-> ##[1:4] ack)
        else begin
            $display("%s: ack never rose after req", test_name);
            err_count++;
        end

    ack_holds: assert property (@(posedge clk) disable iff (rst) (ack && req) |=> ack)
        else begin
            $display("%s: ack fell while req was still high", test_name);
            err_count++;
        end

    rsp_holds: assert property (@(posedge clk) disable iff (rst)
        (ack && $past(ack)) |-> $stable(rsp))
        else begin
            $display("%s: rsp changed while ack was high", test_name);
            err_count++;
        end

    function automatic alu_rsp_t ref_model(input alu_req_t r);
        alu_rsp_t                    o;
        logic [MSB+1:0]              wide;
        logic signed [MSB:0]         sa;
        logic [`ALU_SHAMT_BITS-1:0]  sh;
        logic                        is_sub;
        o      = '0;
        sa     = r.a;
        sh     = r.b[`ALU_SHAMT_BITS-1:0];
        is_sub = (r.op == OP_SLT) || (r.op == OP_SLTU) || (r.op == OP_ADD && r.sub);
        if (is_sub) begin
            wide = {1'b0, r.a} - {1'b0, r.b};
            // carry set means no borrow
            o.flags.carry    = (r.a >= r.b);
            o.flags.overflow = (r.a[MSB] != r.b[MSB]) && (wide[MSB] != r.a[MSB]);
        end else begin
            wide = {1'b0, r.a} + {1'b0, r.b};
            o.flags.carry    = wide[MSB+1];
            o.flags.overflow = (r.a[MSB] == r.b[MSB]) && (wide[MSB] != r.a[MSB]);
        end
        o.flags.zero     = (wide[MSB:0] == '0);
        o.flags.negative = wide[MSB];
        case (r.op)
            OP_ADD:  o.result = wide[MSB:0];
            OP_SLT:  o.result = ($signed(r.a) < $signed(r.b)) ? 1 : 0;
            OP_SLTU: o.result = (r.a < r.b) ? 1 : 0;
            default: begin
                o.flags = '0;
                case (r.op)
                    OP_SLL: o.result = r.a << sh;
                    OP_XOR: o.result = r.a ^ r.b;
                    OP_OR:  o.result = r.a | r.b;
                    OP_AND: o.result = r.a & r.b;
                    default: begin
                        if (r.arith) begin
                            o.result = sa >>> sh;
                        end else begin
                            o.result = r.a >> sh;
                        end
                    end
                endcase
            end
        endcase
        return o;
    endfunction

    function automatic logic [MSB:0] random_word();
        return {$urandom(), $urandom()};
    endfunction

    function automatic alu_req_t make_req(input alu_op_e op, input logic [MSB:0] a,
                                          input logic [MSB:0] b, input logic sub,
                                          input logic arith);
        alu_req_t r;
        r.op    = op;
        r.a     = a;
        r.b     = b;
        r.sub   = sub;
        r.arith = arith;
        return r;
    endfunction

    function automatic alu_req_t random_req();
        return make_req(alu_op_e'($urandom_range(7, 0)), random_word(), random_word(),
                        $urandom_range(1, 0), $urandom_range(1, 0));
    endfunction

    // full four-phase cycle, req held 0 to 3 extra cycles
    task automatic run_op(input alu_req_t r);
        int extra;
        extra = $urandom_range(3, 0);
        @(posedge clk);
        req_data <= r;
        exp_rsp  <= ref_model(r);
        req      <= 1'b1;
        sent_count++;
        @(negedge clk);
        while (!ack) @(negedge clk);
        repeat (extra) @(negedge clk);
        @(posedge clk);
        req <= 1'b0;
        @(negedge clk);
        while (ack) @(negedge clk);
    endtask

    task automatic begin_test(input string name);
        test_name       = name;
        test_start_errs = err_count;
        sent_start      = sent_count;
        rises_start     = ack_rises;
    endtask

    task automatic end_test();
        one_response: assert (ack_rises - rises_start == sent_count - sent_start)
            else begin
                $display("%s: %0d requests drew %0d responses", test_name,
                         sent_count - sent_start, ack_rises - rises_start);
                err_count++;
            end
        if (err_count == test_start_errs) begin
            tests_pass++;
            $display("test %s passed, %0d requests", test_name, sent_count - sent_start);
        end else begin
            tests_fail++;
            $display("test %s failed, %0d errors", test_name, err_count - test_start_errs);
        end
    endtask

    initial begin
        logic [MSB:0]                a;
        logic [MSB:0]                b;
        logic [`ALU_SHAMT_BITS-1:0]  fixed_shamt [3];
        void'($urandom(94760));
        clk         = 1'b0;
        rst         = 1'b1;
        req         = 1'b0;
        req_data    = '0;
        exp_rsp     = '0;
        err_count   = 0;
        tests_pass  = 0;
        tests_fail  = 0;
        sent_count  = 0;
        ack_rises   = 0;
        corner[0]   = '0;
        corner[1]   = '1;
        corner[2]   = {1'b0, {MSB{1'b1}}};
        corner[3]   = {1'b1, {MSB{1'b0}}};
        fixed_shamt = '{0, 1, 63};
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);

        begin_test("reset");
        reset_ack: assert (ack == 1'b0)
            else begin
                $display("reset: ack is high after reset");
                err_count++;
            end
        end_test();

        begin_test("add_sub");
        for (int i = 0; i < 4; i++) begin
            for (int j = 0; j < 4; j++) begin
                run_op(make_req(OP_ADD, corner[i], corner[j], 1'b0, 1'b0));
                run_op(make_req(OP_ADD, corner[i], corner[j], 1'b1, 1'b0));
            end
        end
        end_test();

        begin_test("compare");
        for (int i = 0; i < 4; i++) begin
            for (int j = 0; j < 4; j++) begin
                run_op(make_req(OP_SLT, corner[i], corner[j], 1'b0, 1'b0));
                run_op(make_req(OP_SLTU, corner[i], corner[j], 1'b0, 1'b0));
            end
        end
        end_test();

        // upper bits of b left random to show they are ignored
        begin_test("shift");
        for (int k = 0; k < 2; k++) begin
            a      = random_word();
            a[MSB] = k[0];
            for (int m = 0; m < 5; m++) begin
                b = random_word();
                if (m < 3) begin
                    b[`ALU_SHAMT_BITS-1:0] = fixed_shamt[m];
                end
                run_op(make_req(OP_SLL, a, b, 1'b0, 1'b0));
                run_op(make_req(OP_SRL, a, b, 1'b0, 1'b0));
                run_op(make_req(OP_SRL, a, b, 1'b0, 1'b1));
            end
        end
        end_test();

        begin_test("bitwise");
        for (int p = 0; p < 5; p++) begin
            a = (p == 3) ? {(`ALU_XLEN / 2){2'b10}} : random_word();
            b = (p == 3) ? {(`ALU_XLEN / 2){2'b01}} : random_word();
            if (p == 4) begin
                a = {(`ALU_XLEN / 16){16'hff00}};
                b = {(`ALU_XLEN / 8){8'h0f}};
            end
            run_op(make_req(OP_XOR, a, b, $urandom_range(1, 0), $urandom_range(1, 0)));
            run_op(make_req(OP_OR, a, b, $urandom_range(1, 0), $urandom_range(1, 0)));
            run_op(make_req(OP_AND, a, b, $urandom_range(1, 0), $urandom_range(1, 0)));
        end
        end_test();

        begin_test("back_to_back");
        repeat (10) run_op(random_req());
        end_test();

        begin_test("random_mix");
        repeat (200) run_op(random_req());
        end_test();

        $display("tests passed %0d, failed %0d, errors %0d", tests_pass, tests_fail, err_count);
        if (err_count == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    // ten cycles per request, doubled
    initial begin
        #(TXN_TOTAL * 10 * CLK_PERIOD * 2);
        $display("timeout: run did not finish within %0d ns", TXN_TOTAL * 10 * CLK_PERIOD * 2);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

/* files.f */
+incdir+verilog
verilog/alu_pkg.sv
verilog/alu_handshake.sv
verilog/alu_arith.sv
verilog/alu_logic_shift.sv
verilog/alu_result_merge.sv
verilog/alu_unit.sv
bench/tb_alu_unit.sv
